//--- sim.f
+incdir+.
fp2_pkg.sv
fp2_col_seq.sv
fp2_mac.sv
fp2_result_bank.sv
fp2_mul.sv
tb_fp2_mul.sv

//--- Makefile
# Verilator lint and simulation of the F(p^2) product core

TB_TOP := tb_fp2_mul
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module fp2_mul

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TB_TOP) --Mdir $(OBJ)
	./$(OBJ)/V$(TB_TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- tb_fp2_mul.sv
/*
 * Directed testbench for the F(p^2) product core. Models the four
 * operand memories, runs each test against a wide-integer reference
 * and compares every result digit read back through the host port.
 */

`timescale 1ns/1ns
`default_nettype none

`include "fp2_consts.svh"

module tb_fp2_mul;

  import fp2_pkg::*;

  localparam int radix = `FP2_RADIX;
  localparam int digits = `FP2_DIGITS;
  localparam int res_digits = `FP2_RES_DIGITS;
  localparam int part_w = digits * radix;
  localparam int res_w = 2 * part_w;
  localparam int max_cycles = 4 * digits * digits + 64;

  typedef logic [part_w-1:0] part_t;
  typedef logic [res_w-1:0] wide_t;

  logic      clk;
  logic      rst;
  logic      start;
  logic      busy;
  logic      done;
  logic      op_rd_en;
  op_addr_t  a_addr;
  op_addr_t  b_addr;
  digit_t    a0_dout = '0;
  digit_t    a1_dout = '0;
  digit_t    b0_dout = '0;
  digit_t    b1_dout = '0;
  res_addr_t res_addr;
  digit_t    res_sub;
  digit_t    res_add;

  digit_t a0_mem [digits];
  digit_t a1_mem [digits];
  digit_t b0_mem [digits];
  digit_t b1_mem [digits];

  // operand values behind the memories
  part_t op_a0;
  part_t op_a1;
  part_t op_b0;
  part_t op_b1;

  fp2_mul u_dut (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .op_rd_en (op_rd_en),
    .a_addr   (a_addr),
    .b_addr   (b_addr),
    .a0_dout  (a0_dout),
    .a1_dout  (a1_dout),
    .b0_dout  (b0_dout),
    .b1_dout  (b1_dout),
    .res_addr (res_addr),
    .res_sub  (res_sub),
    .res_add  (res_add)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // synchronous operand memories, one cycle read latency
  always @(posedge clk) begin
    if (op_rd_en) begin
      a0_dout <= a0_mem[a_addr];
      a1_dout <= a1_mem[a_addr];
      b0_dout <= b0_mem[b_addr];
      b1_dout <= b1_mem[b_addr];
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t ns: %s, got %0h expected %0h",
                          $time, what, got, exp));
    end
  endtask

  function automatic part_t rand_part();
    part_t v;
    for (int i = 0; i < digits; i++) begin
      v[i*radix +: radix] = digit_t'($urandom);
    end
    return v;
  endfunction

  task automatic load_operands(input part_t a0, input part_t a1,
                               input part_t b0, input part_t b1);
    op_a0 = a0;
    op_a1 = a1;
    op_b0 = b0;
    op_b1 = b1;
    for (int i = 0; i < digits; i++) begin
      a0_mem[i] = a0[i*radix +: radix];
      a1_mem[i] = a1[i*radix +: radix];
      b0_mem[i] = b0[i*radix +: radix];
      b1_mem[i] = b1[i*radix +: radix];
    end
  endtask

  // flip every stored digit, the reference operands stay as they were
  task automatic invert_operand_memories();
    for (int i = 0; i < digits; i++) begin
      a0_mem[i] = ~a0_mem[i];
      a1_mem[i] = ~a1_mem[i];
      b0_mem[i] = ~b0_mem[i];
      b1_mem[i] = ~b1_mem[i];
    end
  endtask

  // wide products, both parts wrap at 2*digits digits
  task automatic model_results(output wide_t sub_ref, output wide_t add_ref);
    wide_t x0;
    wide_t x1;
    wide_t y0;
    wide_t y1;
    x0 = wide_t'(op_a0);
    x1 = wide_t'(op_a1);
    y0 = wide_t'(op_b0);
    y1 = wide_t'(op_b1);
    sub_ref = x0 * y0 - x1 * y1;
    add_ref = x0 * y1 + x1 * y0;
  endtask

  // pulse start, then follow busy and done until the run ends
  task automatic run_core(input bit extra_start);
    int cycles;
    bit stray_sent;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_value(64'(busy), 64'd1, "busy after start");
    cycles = 0;
    stray_sent = 1'b0;
    while (!done) begin
      check_value(64'(busy), 64'd1, "busy before done");
      start = 1'b0;
      // second start after the last read, against changed memories
      if (extra_start && !stray_sent && !op_rd_en) begin
        start = 1'b1;
        stray_sent = 1'b1;
        invert_operand_memories();
      end
      @(negedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        abort_run($sformatf("timeout: done did not arrive within %0d cycles", max_cycles));
      end
    end
    start = 1'b0;
    if (extra_start && !stray_sent) begin
      abort_run("the second start could not be issued while busy was high");
    end
    check_value(64'(busy), 64'd0, "busy falls with done");
    @(negedge clk);
    check_value(64'(done), 64'd0, "done is a single cycle pulse");
  endtask

  task automatic watch_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value(64'(done), 64'd0, "no further done");
      check_value(64'(busy), 64'd0, "busy stays low");
    end
  endtask

  task automatic read_results(output wide_t sub_got, output wide_t add_got);
    for (int k = 0; k < res_digits; k++) begin
      @(negedge clk);
      res_addr = res_addr_t'(k);
      @(negedge clk);
      sub_got[k*radix +: radix] = res_sub;
      add_got[k*radix +: radix] = res_add;
    end
  endtask

  task automatic check_results(input string name);
    wide_t sub_ref;
    wide_t add_ref;
    wide_t sub_got;
    wide_t add_got;
    model_results(sub_ref, add_ref);
    read_results(sub_got, add_got);
    for (int k = 0; k < res_digits; k++) begin
      check_value(64'(sub_got[k*radix +: radix]), 64'(sub_ref[k*radix +: radix]),
                  $sformatf("%s sub digit %0d", name, k));
      check_value(64'(add_got[k*radix +: radix]), 64'(add_ref[k*radix +: radix]),
                  $sformatf("%s add digit %0d", name, k));
    end
  endtask

  function automatic bit every_digit_differs(input wide_t x, input wide_t y);
    for (int k = 0; k < res_digits; k++) begin
      if (x[k*radix +: radix] == y[k*radix +: radix]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic after_reset();
    check_value(64'(busy), 64'd0, "busy after reset");
    check_value(64'(done), 64'd0, "done after reset");
    check_value(64'(op_rd_en), 64'd0, "op_rd_en after reset");
    load_operands(part_t'(1), part_t'(2), part_t'(3), part_t'(4));
    run_core(1'b0);
    check_results("after reset");
  endtask

  task automatic small_operands();
    // a = 3 + 5i, b = 7 + 2i
    load_operands(part_t'(3), part_t'(5), part_t'(7), part_t'(2));
    run_core(1'b0);
    check_results("small");
  endtask

  task automatic negative_sub();
    // sub = -5, every upper digit all ones
    load_operands(part_t'(0), part_t'(1), part_t'(0), part_t'(5));
    run_core(1'b0);
    check_results("negative small");
    load_operands(part_t'(2), '1, part_t'(3), '1);
    run_core(1'b0);
    check_results("negative wide");
    // carries ripple through every column
    load_operands('1, '1, '1, '1);
    run_core(1'b0);
    check_results("all ones");
  endtask

  task automatic random_operands();
    for (int n = 0; n < 10; n++) begin
      load_operands(rand_part(), rand_part(), rand_part(), rand_part());
      run_core(1'b0);
      check_results($sformatf("random %0d", n));
    end
  endtask

  task automatic start_while_busy();
    load_operands(rand_part(), rand_part(), rand_part(), rand_part());
    run_core(1'b1);
    watch_idle(max_cycles);
    check_results("start while busy");
  endtask

  task automatic back_to_back();
    wide_t prev_sub;
    wide_t prev_add;
    wide_t next_sub;
    wide_t next_add;
    bit    fresh;
    int    tries;
    load_operands(rand_part(), rand_part(), rand_part(), rand_part());
    run_core(1'b0);
    check_results("first of pair");
    model_results(prev_sub, prev_add);
    fresh = 1'b0;
    tries = 0;
    while (!fresh && tries < 32) begin
      load_operands(rand_part(), rand_part(), rand_part(), rand_part());
      model_results(next_sub, next_add);
      fresh = every_digit_differs(prev_sub, next_sub) && every_digit_differs(prev_add, next_add);
      tries++;
    end
    if (!fresh) begin
      abort_run("could not pick operands that change every result digit");
    end
    run_core(1'b0);
    check_results("second of pair");
  endtask

  initial begin
    void'($urandom(28));
    rst = 1'b1;
    start = 1'b0;
    res_addr = '0;
    load_operands('0, '0, '0, '0);
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    after_reset();
    small_operands();
    negative_sub();
    random_operands();
    start_while_busy();
    back_to_back();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- fp2_mul.sv
/*
 * Top of the digit-serial F(p^2) product core.
 * Pulse start while busy is low, wait for done, then read the sub and
 * add parts back through res_addr. Operand memories must answer one
 * cycle after op_rd_en.
 */

`timescale 1ns/1ns
`default_nettype none

module fp2_mul (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      start,
  output logic                     busy,
  output logic                     done,
  output logic                     op_rd_en,
  output fp2_pkg::op_addr_t        a_addr,
  output fp2_pkg::op_addr_t        b_addr,
  input  wire fp2_pkg::digit_t     a0_dout,
  input  wire fp2_pkg::digit_t     a1_dout,
  input  wire fp2_pkg::digit_t     b0_dout,
  input  wire fp2_pkg::digit_t     b1_dout,
  input  wire fp2_pkg::res_addr_t  res_addr,
  output fp2_pkg::digit_t          res_sub,
  output fp2_pkg::digit_t          res_add
);

  import fp2_pkg::*;

  logic      pair_valid;
  logic      col_first;
  logic      col_last;
  res_addr_t col_idx;
  logic      wr_en;
  res_addr_t wr_col;
  digit_t    sub_digit;
  digit_t    add_digit;

  fp2_col_seq u_col_seq (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .op_rd_en   (op_rd_en),
    .a_addr     (a_addr),
    .b_addr     (b_addr),
    .pair_valid (pair_valid),
    .col_first  (col_first),
    .col_last   (col_last),
    .col_idx    (col_idx),
    .wr_en      (wr_en)
  );

  // real part a0*b0 - a1*b1
  fp2_mac #(.subtract(1'b1)) u_mac_sub (
    .clk        (clk),
    .rst        (rst),
    .pair_valid (pair_valid),
    .col_first  (col_first),
    .col_last   (col_last),
    .col_idx    (col_idx),
    .x0         (a0_dout),
    .x1         (a1_dout),
    .y0         (b0_dout),
    .y1         (b1_dout),
    .wr_en      (wr_en),
    .wr_col     (wr_col),
    .wr_digit   (sub_digit)
  );

  // imaginary part a0*b1 + a1*b0, same timing as the sub side
  fp2_mac #(.subtract(1'b0)) u_mac_add (
    .clk        (clk),
    .rst        (rst),
    .pair_valid (pair_valid),
    .col_first  (col_first),
    .col_last   (col_last),
    .col_idx    (col_idx),
    .x0         (a0_dout),
    .x1         (a1_dout),
    .y0         (b1_dout),
    .y1         (b0_dout),
    .wr_en      (),
    .wr_col     (),
    .wr_digit   (add_digit)
  );

  fp2_result_bank u_result_bank (
    .clk       (clk),
    .wr_en     (wr_en),
    .wr_col    (wr_col),
    .sub_digit (sub_digit),
    .add_digit (add_digit),
    .res_addr  (res_addr),
    .res_sub   (res_sub),
    .res_add   (res_add)
  );

endmodule

`default_nettype wire

//--- fp2_result_bank.sv
/*
 * Result storage for the sub and add parts, one digit per column.
 * The accumulators share the write port; the host reads both parts at
 * res_addr with one cycle of latency once the run is over.
 */

`timescale 1ns/1ns
`default_nettype none

`include "fp2_consts.svh"

module fp2_result_bank (
  input  wire                      clk,
  input  wire                      wr_en,
  input  wire fp2_pkg::res_addr_t  wr_col,
  input  wire fp2_pkg::digit_t     sub_digit,
  input  wire fp2_pkg::digit_t     add_digit,
  input  wire fp2_pkg::res_addr_t  res_addr,
  output fp2_pkg::digit_t          res_sub,
  output fp2_pkg::digit_t          res_add
);

  import fp2_pkg::*;

  digit_t sub_mem [`FP2_RES_DIGITS];
  digit_t add_mem [`FP2_RES_DIGITS];

  // both parts land in the same column together
  always_ff @(posedge clk) begin
    if (wr_en) begin
      sub_mem[wr_col] <= sub_digit;
      add_mem[wr_col] <= add_digit;
    end
  end

  // registered host read
  always_ff @(posedge clk) begin
    res_sub <= sub_mem[res_addr];
    res_add <= add_mem[res_addr];
  end

endmodule

`default_nettype wire

//--- fp2_mac.sv
/*
 * Column multiply-accumulate for one part of the F(p^2) product.
 * subtract = 1 forms x0*y0 - x1*y1, subtract = 0 forms x0*y0 + x1*y1.
 * Each column starts from the signed carry of the one before and writes
 * its low digit one cycle after its last pair.
 */

`timescale 1ns/1ns
`default_nettype none

`include "fp2_consts.svh"

module fp2_mac #(
  parameter bit subtract = 1'b0
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      pair_valid,
  input  wire                      col_first,
  input  wire                      col_last,
  input  wire fp2_pkg::res_addr_t  col_idx,
  input  wire fp2_pkg::digit_t     x0,
  input  wire fp2_pkg::digit_t     x1,
  input  wire fp2_pkg::digit_t     y0,
  input  wire fp2_pkg::digit_t     y1,
  output logic                     wr_en,
  output fp2_pkg::res_addr_t       wr_col,
  output fp2_pkg::digit_t          wr_digit
);

  import fp2_pkg::*;

  localparam int prod_w = 2 * `FP2_RADIX;
  localparam res_addr_t top_col = res_addr_t'(`FP2_RES_DIGITS - 1);

  typedef logic [prod_w-1:0] prod_t;

  prod_t p0;
  prod_t p1;
  acc_t  term;
  acc_t  seed;
  acc_t  total;
  acc_t  acc;
  acc_t  carry;

  assign p0 = prod_t'(x0) * prod_t'(y0);
  assign p1 = prod_t'(x1) * prod_t'(y1);

  // the top column only takes the final carry
  assign term = (col_idx == top_col) ? '0 :
                subtract ? acc_t'(p0) - acc_t'(p1) : acc_t'(p0) + acc_t'(p1);

  // column 0 has no carry in
  assign seed = col_first ? ((col_idx == '0) ? '0 : carry) : acc;
  assign total = seed + term;

  always_ff @(posedge clk) begin
    if (pair_valid) begin
      acc <= total;
    end
    if (pair_valid && col_last) begin
      wr_digit <= total[`FP2_RADIX-1:0];
      wr_col <= col_idx;
      carry <= total >>> `FP2_RADIX;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= pair_valid && col_last;
    end
  end

  // a column seeds from the carry of the column written just before it
  a_carry_ready: assert property (@(posedge clk) disable iff (rst)
    pair_valid && col_first && col_idx != '0 |-> wr_en && wr_col == col_idx - res_addr_t'(1));

endmodule

`default_nettype wire

//--- fp2_col_seq.sv
/*
 * Product-scanning sequencer. Walks every result column and the digit
 * pairs that feed it, one pair per cycle, drives the operand reads and
 * hands column flags to the accumulators aligned with the read data.
 * Counts result writes to close the run with done.
 */

`timescale 1ns/1ns
`default_nettype none

`include "fp2_consts.svh"

module fp2_col_seq (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 start,
  output logic                busy,
  output logic                done,
  output logic                op_rd_en,
  output fp2_pkg::op_addr_t   a_addr,
  output fp2_pkg::op_addr_t   b_addr,
  output logic                pair_valid,
  output logic                col_first,
  output logic                col_last,
  output fp2_pkg::res_addr_t  col_idx,
  input  wire                 wr_en
);

  import fp2_pkg::*;

  localparam res_addr_t last_col = res_addr_t'(`FP2_RES_DIGITS - 1);
  localparam res_addr_t digits_r = res_addr_t'(`FP2_DIGITS);
  localparam res_addr_t d_minus_1 = res_addr_t'(`FP2_DIGITS - 1);

  seq_state_t state;
  res_addr_t  col;
  op_addr_t   pair;
  res_addr_t  wr_cnt;
  logic       accept;
  logic       issue;
  op_addr_t   cur_lo;
  op_addr_t   cur_hi;
  op_addr_t   next_lo;

  // first pair index of column k
  function automatic op_addr_t pair_lo(input res_addr_t k);
    // top column has no real pair, one dummy read carries its flags
    if (k == last_col) begin
      return op_addr_t'(d_minus_1);
    end
    if (k >= digits_r) begin
      return op_addr_t'(k - d_minus_1);
    end
    return '0;
  endfunction

  // last pair index of column k
  function automatic op_addr_t pair_hi(input res_addr_t k);
    if (k < digits_r) begin
      return op_addr_t'(k);
    end
    return op_addr_t'(d_minus_1);
  endfunction

  assign accept = start && !busy;
  assign issue = (state == run);

  assign cur_lo = pair_lo(col);
  assign cur_hi = pair_hi(col);
  assign next_lo = pair_lo(col + res_addr_t'(1));

  // a digit j, b digit k-j
  assign op_rd_en = issue;
  assign a_addr = pair;
  assign b_addr = op_addr_t'(col - res_addr_t'(pair));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      busy <= 1'b0;
      done <= 1'b0;
      col <= '0;
      pair <= '0;
      wr_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        state <= run;
        busy <= 1'b1;
        col <= '0;
        pair <= '0;
        wr_cnt <= '0;
      end else begin
        if (wr_en) begin
          wr_cnt <= wr_cnt + res_addr_t'(1);
        end
        case (state)
          run: begin
            if (pair == cur_hi) begin
              if (col == last_col) begin
                state <= drain;
              end else begin
                col <= col + res_addr_t'(1);
                pair <= next_lo;
              end
            end else begin
              pair <= pair + op_addr_t'(1);
            end
          end
          drain: begin
            // last column written
            if (wr_en && wr_cnt == last_col) begin
              done <= 1'b1;
              busy <= 1'b0;
            end
            if (done) begin
              state <= idle;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // flags follow the one-cycle memory read
  always_ff @(posedge clk) begin
    if (rst) begin
      pair_valid <= 1'b0;
      col_first <= 1'b0;
      col_last <= 1'b0;
    end else begin
      pair_valid <= issue;
      col_first <= issue && (pair == cur_lo);
      col_last <= issue && (pair == cur_hi);
    end
  end

  always_ff @(posedge clk) begin
    col_idx <= col;
  end

  a_done_not_idle: assert property (@(posedge clk) disable iff (rst)
    done |-> state != idle);

  // columns follow each other without a skip
  a_col_in_order: assert property (@(posedge clk) disable iff (rst)
    pair_valid && col_first && col_idx != '0 |-> col_idx == $past(col_idx) + res_addr_t'(1));

endmodule

`default_nettype wire

//--- fp2_pkg.sv
/*
 * Shared types of the F(p^2) product core.
 * Ports name them by scope, module bodies import the package.
 */

`default_nettype none

`include "fp2_consts.svh"

package fp2_pkg;

  typedef logic [`FP2_RADIX-1:0] digit_t;
  typedef logic [`FP2_DIGIT_AW-1:0] op_addr_t;
  typedef logic [`FP2_RES_AW-1:0] res_addr_t;

  // column sum, carry kept signed for the sub part
  typedef logic signed [`FP2_ACC_W-1:0] acc_t;

  typedef enum logic [1:0] {
    idle,
    run,
    drain
  } seq_state_t;

endpackage

`default_nettype wire

//--- fp2_consts.svh
/*
 * Sizing constants for the F(p^2) product core.
 * Include in any file that needs digit or address widths.
 */

`ifndef FP2_CONSTS_SVH
`define FP2_CONSTS_SVH

// bits per digit and digits per operand part
`define FP2_RADIX 16
`define FP2_DIGITS 4

`define FP2_DIGIT_AW ((`FP2_DIGITS > 1) ? $clog2(`FP2_DIGITS) : 1)
`define FP2_RES_DIGITS (2 * `FP2_DIGITS)
`define FP2_RES_AW $clog2(`FP2_RES_DIGITS)

// two digits, pair growth, sign and one spare
`define FP2_ACC_W (2 * `FP2_RADIX + $clog2(`FP2_DIGITS) + 2)

`endif
